// ==== Bender.yml ====
package:
  name: lidar_tdc

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/lidar_pkg.sv
      - verilog/tdc_spi_master.sv
      - verilog/tdc_control.sv
      - verilog/result_fifo.sv
      - verilog/result_uart.sv
      - verilog/lidar_tdc_top.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - sim/tdc_slave_model.sv
      - sim/lidar_tdc_tb.sv

// ==== flist.f ====
+incdir+verilog
verilog/lidar_pkg.sv
verilog/tdc_spi_master.sv
verilog/tdc_control.sv
verilog/result_fifo.sv
verilog/result_uart.sv
verilog/lidar_tdc_top.sv
sim/tdc_slave_model.sv
sim/lidar_tdc_tb.sv

// ==== sim/lidar_tdc_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "lidar_defs.svh"

module lidar_tdc_tb;

  // short shot period so the uart falls behind and the fifo fills
  localparam int shot_div = 320;
  localparam int baud = `LIDAR_BAUD_DIV;
  localparam int word_cycles = 40 * baud;
  localparam int total_shots = 70;
  localparam int pause_cycles = 3 * shot_div;
  localparam int watchdog_cycles =
    2 * (total_shots * (2 * shot_div + word_cycles) + 2 * pause_cycles);

  logic clk;
  logic rst;
  logic enable;
  logic pause;
  wire  tdc_intb;
  wire  tdc_dout;
  wire  tdc_enable;
  wire  tdc_start_signal;
  wire  tdc_ref_clock;
  wire  tdc_cs;
  wire  tdc_sck;
  wire  tdc_mosi;
  wire  serial_out;

  // setup of the next shot, read by the tdc model
  logic        shot_miss;
  logic [7:0]  shot_delay;
  logic [23:0] shot_tof;
  logic        force_miss;
  logic [31:0] rng_state;
  int          model_reads;
  int          model_cmd_errors;

  // reference model
  logic [31:0] exp_q[$];
  logic [7:0]  next_shot;
  logic        start_prev;
  int          start_count;
  int          exp_reads;
  int          exp_missed;
  int          rx_count;
  int          rx_missed;
  int          full_cycles;
  int          errors;
  int          tests_run;
  int          tests_failed;

  lidar_tdc_top #(
    .shot_div(shot_div)
  ) u_lidar_tdc_top (
    .clk             (clk),
    .rst             (rst),
    .enable          (enable),
    .pause           (pause),
    .tdc_intb        (tdc_intb),
    .tdc_dout        (tdc_dout),
    .tdc_enable      (tdc_enable),
    .tdc_start_signal(tdc_start_signal),
    .tdc_ref_clock   (tdc_ref_clock),
    .tdc_cs          (tdc_cs),
    .tdc_sck         (tdc_sck),
    .tdc_mosi        (tdc_mosi),
    .serial_out      (serial_out)
  );

  tdc_slave_model u_tdc_slave_model (
    .clk         (clk),
    .start_signal(tdc_start_signal),
    .cs          (tdc_cs),
    .sck         (tdc_sck),
    .mosi        (tdc_mosi),
    .miss        (shot_miss),
    .delay       (shot_delay),
    .tof         (shot_tof),
    .intb        (tdc_intb),
    .dout        (tdc_dout),
    .reads       (model_reads),
    .cmd_errors  (model_cmd_errors)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // echo delay, about one miss in eight, random time value
  task automatic draw_shot();
    rng_state  = lcg_next(rng_state);
    shot_delay = 8'd4 + {1'b0, rng_state[30:24]};
    shot_miss  = force_miss || (rng_state[18:16] == 3'd0);
    rng_state  = lcg_next(rng_state);
    shot_tof   = rng_state[31:8];
  endtask

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    if (got !== exp) begin
      $display("error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  // expected word queued per start pulse, next draw on its fall
  always @(negedge clk) begin
    if (tdc_start_signal === 1'b1 && !start_prev) begin
      exp_q.push_back({next_shot, shot_miss ? 24'hffffff : shot_tof});
      next_shot = next_shot + 8'd1;
      start_count++;
      if (shot_miss) begin
        exp_missed++;
      end else begin
        exp_reads++;
      end
    end else if (tdc_start_signal === 1'b0 && start_prev) begin
      draw_shot();
    end
    start_prev = (tdc_start_signal === 1'b1);
    if (u_lidar_tdc_top.fifo_full === 1'b1) begin
      full_cycles++;
    end
  end

  // 8N1 byte, sampled mid bit
  task automatic receive_byte(output logic [7:0] data);
    int i;
    @(negedge clk);
    while (serial_out !== 1'b0) @(negedge clk);
    repeat (baud / 2 - 1) @(negedge clk);
    if (serial_out !== 1'b0) begin
      $display("uart start bit too short at %0d ns", $time);
      errors++;
    end
    for (i = 0; i < 8; i++) begin
      repeat (baud) @(negedge clk);
      data[i] = serial_out;
    end
    repeat (baud) @(negedge clk);
    if (serial_out !== 1'b1) begin
      $display("uart stop bit missing at %0d ns", $time);
      errors++;
    end
  endtask

  // rebuilds words, shot byte first
  initial begin : uart_decoder
    int          n;
    logic [7:0]  rx_byte;
    logic [31:0] word;
    logic [31:0] exp_word;
    @(negedge rst);
    forever begin
      for (n = 0; n < 4; n++) begin
        receive_byte(rx_byte);
        word = {word[23:0], rx_byte};
      end
      if (exp_q.size() == 0) begin
        $display("word %h arrived at %0d ns with no shot fired for it", word, $time);
        errors++;
      end else begin
        exp_word = exp_q.pop_front();
        check_value(word, exp_word, "uart word");
      end
      check_value(word[31:24], rx_count[7:0], "shot number");
      if (word[23:0] == 24'hffffff) begin
        rx_missed++;
      end
      rx_count++;
    end
  end

  // tdc reference clock half period while enabled
  task automatic check_ref_clock();
    int   run;
    int   toggles;
    logic last;
    run     = 0;
    toggles = 0;
    @(negedge clk);
    last = tdc_ref_clock;
    repeat (8 * `LIDAR_REF_DIV) begin
      @(negedge clk);
      run++;
      if (tdc_ref_clock !== last) begin
        // first interval starts mid period
        if (toggles > 0) begin
          check_value(run, `LIDAR_REF_DIV, "tdc_ref_clock half period");
        end
        toggles++;
        run  = 0;
        last = tdc_ref_clock;
      end
    end
    check_value(toggles >= 6, 1, "tdc_ref_clock toggles while enabled");
  endtask

  task automatic wait_for_starts(input int target);
    int budget;
    int cycles;
    budget = (target - start_count) * (3 * shot_div + 2 * word_cycles);
    cycles = 0;
    while (start_count < target && cycles < budget) begin
      @(negedge clk);
      cycles++;
    end
    if (start_count < target) begin
      $display("only %0d start pulses seen, %0d were due", start_count, target);
      errors++;
    end
  endtask

  // pause, then let the fifo and uart empty out
  task automatic stop_and_drain();
    int budget;
    int cycles;
    budget = ((1 << `LIDAR_FIFO_AW) + 2) * word_cycles + 2 * `LIDAR_INTB_TIMEOUT;
    cycles = 0;
    @(posedge clk);
    pause <= 1'b1;
    repeat (2) @(negedge clk);
    while (rx_count < start_count && cycles < budget) begin
      @(negedge clk);
      cycles++;
    end
    if (rx_count < start_count) begin
      $display("the uart delivered only %0d of %0d words", rx_count, start_count);
      errors++;
    end
  endtask

  task automatic end_test(input int num, input string name, input int errors_before);
    check_value(model_cmd_errors, 0, "wrong tdc command bytes");
    check_value(model_reads, exp_reads, "tdc spi reads");
    tests_run++;
    if (errors == errors_before) begin
      $display("test %0d %s: ok", num, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", num, name, errors - errors_before);
    end
  endtask

  initial begin : main
    int err0;
    int s0;
    int r0;
    int m0;
    int ctrl_seen;
    rst         = 1'b1;
    enable      = 1'b0;
    pause       = 1'b1;
    force_miss  = 1'b0;
    rng_state   = 32'h5349;
    next_shot   = '0;
    start_prev  = 1'b0;
    start_count = 0;
    exp_reads   = 0;
    exp_missed  = 0;
    rx_count    = 0;
    rx_missed   = 0;
    full_cycles = 0;
    errors      = 0;
    tests_run   = 0;
    tests_failed = 0;
    draw_shot();
    repeat (3) @(posedge clk);
    rst <= 1'b0;

    // idle outputs out of reset
    err0 = errors;
    @(negedge clk);
    check_value(serial_out, 1, "serial_out after reset");
    check_value(tdc_cs, 1, "tdc_cs after reset");
    check_value(tdc_sck, 0, "tdc_sck after reset");
    check_value(tdc_start_signal, 0, "tdc_start_signal after reset");
    check_value(tdc_enable, 0, "tdc_enable after reset");
    check_value(tdc_ref_clock, 0, "tdc_ref_clock after reset");
    end_test(1, "reset state", err0);

    err0 = errors;
    @(posedge clk);
    enable <= 1'b1;
    pause  <= 1'b0;
    check_ref_clock();
    wait_for_starts(start_count + 20);
    stop_and_drain();
    end_test(2, "random shots", err0);

    // every shot here misses its echo
    err0 = errors;
    m0 = rx_missed;
    force_miss = 1'b1;
    draw_shot();
    @(posedge clk);
    pause <= 1'b0;
    wait_for_starts(start_count + 6);
    force_miss = 1'b0;
    stop_and_drain();
    check_value(rx_missed - m0 >= 6, 1, "received words with missed echo");
    check_value(rx_missed, exp_missed, "words with missed echo");
    end_test(3, "missed echoes", err0);

    // still paused after the drain
    err0 = errors;
    s0 = start_count;
    r0 = rx_count;
    repeat (pause_cycles) @(negedge clk);
    check_value(start_count, s0, "start pulses while paused");
    check_value(rx_count, r0, "words while paused");
    @(posedge clk);
    enable <= 1'b0;
    pause  <= 1'b0;
    repeat (2) @(negedge clk);
    ctrl_seen = 0;
    repeat (pause_cycles) begin
      @(negedge clk);
      if (tdc_enable !== 1'b0 || tdc_ref_clock !== 1'b0) begin
        ctrl_seen++;
      end
    end
    check_value(ctrl_seen, 0, "cycles with tdc outputs active while disabled");
    check_value(start_count, s0, "start pulses while disabled");
    check_value(rx_count, r0, "words while disabled");
    @(posedge clk);
    enable <= 1'b1;
    wait_for_starts(s0 + 4);
    stop_and_drain();
    end_test(4, "pause and enable", err0);

    // shots outpace the uart until the fifo is full
    err0 = errors;
    full_cycles = 0;
    @(posedge clk);
    pause <= 1'b0;
    wait_for_starts(start_count + 40);
    stop_and_drain();
    check_value(full_cycles > 0, 1, "fifo reached full");
    check_value(rx_count, start_count, "words delivered against shots fired");
    end_test(5, "fifo back-pressure", err0);

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (watchdog_cycles) @(posedge clk);
    $display("the run timed out after %0d clock cycles", watchdog_cycles);
    $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/tdc_slave_model.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "lidar_defs.svh"

module tdc_slave_model (
  input  wire        clk,
  input  wire        start_signal,
  input  wire        cs,
  input  wire        sck,
  input  wire        mosi,
  // echo setup for the coming shot
  input  wire        miss,
  input  wire [7:0]  delay,
  input  wire [23:0] tof,
  output logic       intb,
  output logic       dout,
  output int         reads,
  output int         cmd_errors
);

  logic [23:0] tof_q;
  logic [7:0]  cmd;
  int          k;

  // echo: intb low after the delay, released when the frame closes
  initial begin
    intb = 1'b1;
    forever begin
      @(posedge start_signal);
      tof_q = tof;
      if (!miss) begin
        repeat (delay) @(posedge clk);
        intb <= 1'b0;
        @(posedge cs);
        intb <= 1'b1;
      end
    end
  end

  // one frame is the command byte then three time bytes, msb first
  initial begin
    dout       = 1'b0;
    reads      = 0;
    cmd_errors = 0;
    forever begin
      @(negedge cs);
      cmd = '0;
      for (k = 0; k < 32; k++) begin
        // master samples on rising sck
        @(posedge sck);
        if (k < 8) begin
          cmd = {cmd[6:0], mosi};
        end
        if (k == 7) begin
          reads++;
          if (cmd != `LIDAR_TDC_READ_CMD) begin
            cmd_errors++;
          end
        end
        // next time bit goes out on the falling edge
        @(negedge sck);
        if (k >= 7 && k < 31) begin
          dout <= tof_q[30-k];
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== verilog/lidar_defs.svh ====
`ifndef LIDAR_DEFS_SVH
`define LIDAR_DEFS_SVH

// clk cycles between shot ticks
`define LIDAR_SHOT_DIV 4000

// half period of the tdc reference clock, in clk cycles
`define LIDAR_REF_DIV 2

// half period of the tdc spi clock
`define LIDAR_SPI_DIV 2

// clk cycles per uart bit
`define LIDAR_BAUD_DIV 16

// result fifo depth is 2**aw
`define LIDAR_FIFO_AW 3

// read of the TIME1 register, auto increment off
`define LIDAR_TDC_READ_CMD 8'h10

// cycles to wait for intb before the shot counts as missed
`define LIDAR_INTB_TIMEOUT 600

// start pulse width in clk cycles
`define LIDAR_START_LEN 4

`endif

// ==== verilog/lidar_pkg.sv ====
`default_nettype none

package lidar_pkg;

  // 24-bit time of flight from the tdc
  typedef logic [23:0] tdc_time_t;
  // running shot number
  typedef logic [7:0] shot_id_t;
  typedef logic [7:0] spi_byte_t;

  // one queued measurement, shot number in the top byte
  typedef struct packed {
    shot_id_t  shot;
    tdc_time_t tdc_time;
  } tdc_result_t;

  // request into the spi byte engine
  typedef struct packed {
    logic      start;
    logic      hold_cs;
    spi_byte_t tx;
  } spi_req_t;

  typedef struct packed {
    logic      busy;
    spi_byte_t rx;
  } spi_rsp_t;

  typedef enum logic [2:0] {
    tdc_idle, tdc_fire, tdc_wait_intb, tdc_send_cmd, tdc_read_byte, tdc_push
  } tdc_state_t;

  typedef enum logic [1:0] {uart_idle, uart_start, uart_data, uart_stop} uart_state_t;

endpackage

`default_nettype wire

// ==== verilog/lidar_tdc_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "lidar_defs.svh"

module lidar_tdc_top
  import lidar_pkg::*;
#(
  parameter int shot_div = `LIDAR_SHOT_DIV
) (
  input  wire clk,
  input  wire rst,
  input  wire enable,
  input  wire pause,
  // active low from the tdc
  input  wire tdc_intb,
  input  wire tdc_dout,
  output wire tdc_enable,
  output wire tdc_start_signal,
  output wire tdc_ref_clock,
  output wire tdc_cs,
  output wire tdc_sck,
  output wire tdc_mosi,
  output wire serial_out
);

  spi_req_t    spi_req;
  spi_rsp_t    spi_rsp;
  tdc_result_t fifo_wr_data;
  tdc_result_t fifo_rd_data;
  logic        fifo_wr_en;
  logic        fifo_full;
  logic        fifo_rd_en;
  logic        fifo_empty;

  // shot timing and readout sequence
  tdc_control #(
    .shot_div(shot_div)
  ) u_tdc_control (
    .clk         (clk),
    .rst         (rst),
    .enable      (enable),
    .pause       (pause),
    .intb        (tdc_intb),
    .spi_rsp     (spi_rsp),
    .spi_req     (spi_req),
    .fifo_full   (fifo_full),
    .wr_en       (fifo_wr_en),
    .wr_data     (fifo_wr_data),
    .start_signal(tdc_start_signal),
    .ref_clock   (tdc_ref_clock),
    .tdc_enable  (tdc_enable)
  );

  tdc_spi_master u_tdc_spi_master (
    .clk (clk),
    .rst (rst),
    .req (spi_req),
    .rsp (spi_rsp),
    .miso(tdc_dout),
    .sck (tdc_sck),
    .mosi(tdc_mosi),
    .cs  (tdc_cs)
  );

  result_fifo u_result_fifo (
    .clk    (clk),
    .rst    (rst),
    .wr_en  (fifo_wr_en),
    .wr_data(fifo_wr_data),
    .full   (fifo_full),
    .rd_en  (fifo_rd_en),
    .rd_data(fifo_rd_data),
    .empty  (fifo_empty)
  );

  // four bytes per result on the serial line
  result_uart u_result_uart (
    .clk       (clk),
    .rst       (rst),
    .empty     (fifo_empty),
    .rd_data   (fifo_rd_data),
    .rd_en     (fifo_rd_en),
    .serial_out(serial_out)
  );

endmodule

`default_nettype wire

// ==== verilog/result_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "lidar_defs.svh"

module result_fifo
  import lidar_pkg::*;
(
  input  wire         clk,
  input  wire         rst,
  input  wire         wr_en,
  input  wire         tdc_result_t wr_data,
  output logic        full,
  input  wire         rd_en,
  output tdc_result_t rd_data,
  output logic        empty
);

  localparam int aw = `LIDAR_FIFO_AW;
  localparam int depth = 1 << aw;

  tdc_result_t mem [depth];
  logic [aw-1:0] wr_ptr;
  logic [aw-1:0] rd_ptr;
  logic [aw:0]   count;
  logic          do_wr;
  logic          do_rd;

  // ignore pushes when full and pops when empty
  assign do_wr = wr_en && !full;
  assign do_rd = rd_en && !empty;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) wr_ptr <= wr_ptr + 1'b1;
      if (do_rd) rd_ptr <= rd_ptr + 1'b1;
      case ({do_wr, do_rd})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_wr) mem[wr_ptr] <= wr_data;
  end

  // head word shown without a read cycle
  assign rd_data = mem[rd_ptr];
  assign full    = (count == (aw + 1)'(depth));
  assign empty   = (count == '0);

endmodule

`default_nettype wire

// ==== verilog/result_uart.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "lidar_defs.svh"

module result_uart
  import lidar_pkg::*;
(
  input  wire  clk,
  input  wire  rst,
  input  wire  empty,
  input  wire  tdc_result_t rd_data,
  output logic rd_en,
  output logic serial_out
);

  localparam int baud_div = `LIDAR_BAUD_DIV;
  localparam int baud_w = $clog2(baud_div + 1);

  uart_state_t       state;
  logic [baud_w-1:0] baud_cnt;
  logic [2:0]        bit_cnt;
  logic [1:0]        byte_cnt;
  logic [7:0]        data_sr;
  tdc_time_t         rest_sr;
  logic              baud_end;
  logic              last_byte;
  logic              pop;

  assign baud_end  = (baud_cnt == baud_w'(baud_div - 1));
  assign last_byte = (byte_cnt == 2'd3);
  // next word taken right after the last stop bit, no idle gap
  assign pop   = ((state == uart_idle) || (state == uart_stop && baud_end && last_byte))
                 && !empty;
  assign rd_en = pop;

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= uart_idle;
      baud_cnt   <= '0;
      bit_cnt    <= '0;
      byte_cnt   <= '0;
      serial_out <= 1'b1;
    end else begin
      baud_cnt <= (state == uart_idle || baud_end) ? '0 : baud_cnt + 1'b1;
      case (state)
        uart_idle: begin
          if (pop) begin
            serial_out <= 1'b0;
            byte_cnt   <= '0;
            state      <= uart_start;
          end
        end
        uart_start: begin
          if (baud_end) begin
            serial_out <= data_sr[0];
            bit_cnt    <= '0;
            state      <= uart_data;
          end
        end
        uart_data: begin
          // lsb first
          if (baud_end) begin
            if (bit_cnt == 3'd7) begin
              serial_out <= 1'b1;
              state      <= uart_stop;
            end else begin
              serial_out <= data_sr[1];
              bit_cnt    <= bit_cnt + 3'd1;
            end
          end
        end
        uart_stop: begin
          if (baud_end) begin
            if (!last_byte) begin
              serial_out <= 1'b0;
              byte_cnt   <= byte_cnt + 2'd1;
              state      <= uart_start;
            end else if (pop) begin
              serial_out <= 1'b0;
              byte_cnt   <= '0;
              state      <= uart_start;
            end else begin
              state <= uart_idle;
            end
          end
        end
        default: state <= uart_idle;
      endcase
    end
  end

  // shot byte first, then time high to low
  always_ff @(posedge clk) begin
    if (pop) begin
      data_sr <= rd_data.shot;
      rest_sr <= rd_data.tdc_time;
    end else if (state == uart_data && baud_end) begin
      data_sr <= data_sr >> 1;
    end else if (state == uart_stop && baud_end && !last_byte) begin
      data_sr <= rest_sr[23:16];
      rest_sr <= rest_sr << 8;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/tdc_control.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "lidar_defs.svh"

module tdc_control
  import lidar_pkg::*;
#(
  parameter int shot_div = `LIDAR_SHOT_DIV
) (
  input  wire         clk,
  input  wire         rst,
  input  wire         enable,
  input  wire         pause,
  input  wire         intb,
  input  wire         spi_rsp_t spi_rsp,
  output spi_req_t    spi_req,
  input  wire         fifo_full,
  output logic        wr_en,
  output tdc_result_t wr_data,
  output logic        start_signal,
  output logic        ref_clock,
  output logic        tdc_enable
);

  localparam int ref_div = `LIDAR_REF_DIV;
  localparam int start_len = `LIDAR_START_LEN;
  localparam int timeout = `LIDAR_INTB_TIMEOUT;
  localparam int timer_max = (timeout > start_len) ? timeout : start_len;
  localparam int shot_w = $clog2(shot_div + 1);
  localparam int ref_w = $clog2(ref_div + 1);
  localparam int timer_w = $clog2(timer_max + 1);

  tdc_state_t         state;
  logic [shot_w-1:0]  shot_cnt;
  logic [ref_w-1:0]   ref_cnt;
  logic [timer_w-1:0] timer;
  logic [1:0]         intb_sync;
  logic [1:0]         byte_idx;
  logic               intb_low;
  logic               shot_run;
  logic               shot_tick;
  logic               spi_go;
  logic               spi_done;
  logic               spi_start;
  logic               spi_hold;
  spi_byte_t          spi_tx;
  shot_id_t           shot_id;
  tdc_time_t          meas_time;

  // intb comes straight from the tdc pin
  always_ff @(posedge clk) begin
    if (rst) begin
      intb_sync <= 2'b11;
    end else begin
      intb_sync <= {intb_sync[0], intb};
    end
  end
  assign intb_low = ~intb_sync[1];

  always_ff @(posedge clk) begin
    if (rst) begin
      tdc_enable <= 1'b0;
    end else begin
      tdc_enable <= enable;
    end
  end

  // reference clock, parked low while disabled
  always_ff @(posedge clk) begin
    if (rst || !enable) begin
      ref_cnt   <= '0;
      ref_clock <= 1'b0;
    end else if (ref_cnt == ref_w'(ref_div - 1)) begin
      ref_cnt   <= '0;
      ref_clock <= ~ref_clock;
    end else begin
      ref_cnt <= ref_cnt + 1'b1;
    end
  end

  // shot timer holds its count during pause
  assign shot_run  = enable && !pause;
  assign shot_tick = shot_run && (shot_cnt == shot_w'(shot_div - 1));

  always_ff @(posedge clk) begin
    if (rst) begin
      shot_cnt <= '0;
    end else if (shot_tick) begin
      shot_cnt <= '0;
    end else if (shot_run) begin
      shot_cnt <= shot_cnt + 1'b1;
    end
  end

  // byte finished once busy has been seen high and fell again
  assign spi_done = !spi_go && !spi_rsp.busy;

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= tdc_idle;
      timer        <= '0;
      byte_idx     <= '0;
      spi_go       <= 1'b0;
      spi_start    <= 1'b0;
      spi_hold     <= 1'b0;
      shot_id      <= '0;
      start_signal <= 1'b0;
    end else begin
      spi_start <= 1'b0;
      if (spi_go && spi_rsp.busy) begin
        spi_go <= 1'b0;
      end
      case (state)
        tdc_idle: begin
          // ticks outside idle are dropped
          if (shot_tick) begin
            start_signal <= 1'b1;
            timer        <= '0;
            state        <= tdc_fire;
          end
        end
        tdc_fire: begin
          if (timer == timer_w'(start_len - 1)) begin
            start_signal <= 1'b0;
            timer        <= '0;
            state        <= tdc_wait_intb;
          end else begin
            timer <= timer + 1'b1;
          end
        end
        tdc_wait_intb: begin
          if (intb_low) begin
            // command byte opens the frame
            spi_start <= 1'b1;
            spi_hold  <= 1'b1;
            spi_go    <= 1'b1;
            state     <= tdc_send_cmd;
          end else if (timer == timer_w'(timeout - 1)) begin
            // missed echo
            state <= tdc_push;
          end else begin
            timer <= timer + 1'b1;
          end
        end
        tdc_send_cmd: begin
          if (spi_done) begin
            spi_start <= 1'b1;
            spi_hold  <= 1'b1;
            spi_go    <= 1'b1;
            byte_idx  <= '0;
            state     <= tdc_read_byte;
          end
        end
        tdc_read_byte: begin
          if (spi_done) begin
            if (byte_idx == 2'd2) begin
              state <= tdc_push;
            end else begin
              // cs released after the third data byte
              spi_start <= 1'b1;
              spi_hold  <= (byte_idx != 2'd1);
              spi_go    <= 1'b1;
              byte_idx  <= byte_idx + 2'd1;
            end
          end
        end
        tdc_push: begin
          // stall here on a full fifo
          if (!fifo_full) begin
            shot_id <= shot_id + 1'b1;
            state   <= tdc_idle;
          end
        end
        default: state <= tdc_idle;
      endcase
    end
  end

  // measurement word and tx byte
  always_ff @(posedge clk) begin
    case (state)
      tdc_fire: meas_time <= '1;
      tdc_wait_intb: spi_tx <= `LIDAR_TDC_READ_CMD;
      tdc_send_cmd: spi_tx <= '0;
      tdc_read_byte: begin
        if (spi_done) begin
          meas_time <= {meas_time[15:0], spi_rsp.rx};
        end
      end
      default: ;
    endcase
  end

  assign spi_req = '{start: spi_start, hold_cs: spi_hold, tx: spi_tx};
  assign wr_en   = (state == tdc_push) && !fifo_full;
  assign wr_data = '{shot: shot_id, tdc_time: meas_time};

endmodule

`default_nettype wire

// ==== verilog/tdc_spi_master.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "lidar_defs.svh"

module tdc_spi_master
  import lidar_pkg::*;
(
  input  wire      clk,
  input  wire      rst,
  input  wire      spi_req_t req,
  output spi_rsp_t rsp,
  input  wire      miso,
  output logic     sck,
  output logic     mosi,
  output logic     cs
);

  localparam int half_div = `LIDAR_SPI_DIV;
  localparam int div_w = $clog2(half_div + 1);

  logic [div_w-1:0] div_cnt;
  logic [2:0]       bit_cnt;
  logic             busy;
  logic             hold;
  spi_byte_t        tx_sr;
  spi_byte_t        rx_sr;
  logic             half_end;

  // last clk of one sck half period
  assign half_end = (div_cnt == div_w'(half_div - 1));

  assign rsp.busy = busy;
  assign rsp.rx   = rx_sr;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy    <= 1'b0;
      hold    <= 1'b0;
      div_cnt <= '0;
      bit_cnt <= '0;
      sck     <= 1'b0;
      cs      <= 1'b1;
      mosi    <= 1'b0;
    end else if (!busy) begin
      div_cnt <= '0;
      if (req.start) begin
        // cs drops with the first data bit, half period before sck rises
        busy    <= 1'b1;
        hold    <= req.hold_cs;
        cs      <= 1'b0;
        bit_cnt <= '0;
        mosi    <= req.tx[7];
      end
    end else if (half_end) begin
      div_cnt <= '0;
      sck     <= ~sck;
      if (sck) begin
        // falling edge
        if (bit_cnt == 3'd7) begin
          busy <= 1'b0;
          // keep the frame open for the next byte if asked
          cs   <= ~hold;
        end else begin
          bit_cnt <= bit_cnt + 3'd1;
          mosi    <= tx_sr[6];
        end
      end
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // byte shift registers, msb first
  always_ff @(posedge clk) begin
    if (!busy && req.start) begin
      tx_sr <= req.tx;
    end else if (busy && half_end && sck) begin
      tx_sr <= {tx_sr[6:0], 1'b0};
    end
    // sample on rising sck
    if (busy && half_end && !sck) begin
      rx_sr <= {rx_sr[6:0], miso};
    end
  end

endmodule

`default_nettype wire
